// ==== verilog/ldq_pkg.sv ====
package ldq_pkg;

  // ----------------------------------------
  // sizes
  // ----------------------------------------
  localparam int LDQ_SIZE  = 8;   // top default only
  localparam int DISP_SIZE = 2;   // dispatch slots per cycle
  localparam int CMT_ID_W  = 6;
  localparam int VADDR_W   = 32;

  // ----------------------------------------
  // entry state
  // ----------------------------------------
  typedef enum logic [2:0] {
    LDQ_INIT,           // invalid
    LDQ_ISSUE_WAIT,     // ready to pick
    LDQ_ISSUED,         // in the pipe
    LDQ_EX3_DONE,       // hit, not reported yet
    LDQ_WAIT_COMPLETE   // reported, waiting for commit
  } ldq_state_t;

  // outcome seen at EX2
  typedef enum logic {
    EX2_HIT,
    EX2_MISS
  } ex2_result_t;

endpackage

// ==== verilog/ldq_disp_alloc.sv ====
`timescale 1ns/10ps

module ldq_disp_alloc #(
  parameter int LDQ_SIZE = 8
) (
  input  logic                                  i_clk,
  input  logic                                  i_reset_n,

  input  logic [ldq_pkg::DISP_SIZE-1:0]         i_disp_valid,
  input  logic [ldq_pkg::CMT_ID_W-1:0]          i_disp_cmt_id [ldq_pkg::DISP_SIZE],
  input  logic [ldq_pkg::VADDR_W-1:0]           i_disp_vaddr  [ldq_pkg::DISP_SIZE],

  input  logic                                  i_commit_valid,
  input  logic                                  i_commit_flush,

  output logic [LDQ_SIZE-1:0]                   o_entry_load,
  output logic [ldq_pkg::CMT_ID_W-1:0]          o_entry_cmt_id [LDQ_SIZE],
  output logic [ldq_pkg::VADDR_W-1:0]           o_entry_vaddr  [LDQ_SIZE],

  output logic [$clog2(ldq_pkg::DISP_SIZE+1)-1:0] o_ignored_num
);

  import ldq_pkg::*;

  localparam int IGN_W = $clog2(DISP_SIZE + 1);

  logic [LDQ_SIZE-1:0] r_in_ptr_oh;
  logic                w_flush;
  logic [IGN_W-1:0]    w_disp_cnt;
  logic [IGN_W-1:0]    w_slot_pos [DISP_SIZE];
  logic [LDQ_SIZE-1:0] w_slot_oh  [DISP_SIZE];

  function automatic logic [LDQ_SIZE-1:0] rotl(input logic [LDQ_SIZE-1:0] oh, input int amt);
    logic [2*LDQ_SIZE-1:0] dbl;
    dbl = {oh, oh} << amt;
    return dbl[2*LDQ_SIZE-1:LDQ_SIZE];
  endfunction

  assign w_flush = i_commit_valid & i_commit_flush;

  // compaction: rank of each valid slot
  always_comb begin
    w_disp_cnt = '0;
    for (int s = 0; s < DISP_SIZE; s++) begin
      w_slot_pos[s] = w_disp_cnt;
      w_disp_cnt    = w_disp_cnt + IGN_W'(i_disp_valid[s]);
    end
  end

  always_comb begin
    for (int s = 0; s < DISP_SIZE; s++) begin
      w_slot_oh[s] = (i_disp_valid[s] & !w_flush) ? rotl(r_in_ptr_oh, int'(w_slot_pos[s])) : '0;
    end
  end

  // per-entry write strobe and payload
  always_comb begin
    for (int e = 0; e < LDQ_SIZE; e++) begin
      o_entry_load[e]   = 1'b0;
      o_entry_cmt_id[e] = '0;
      o_entry_vaddr[e]  = '0;
      for (int s = 0; s < DISP_SIZE; s++) begin
        if (w_slot_oh[s][e]) begin
          o_entry_load[e]   = 1'b1;
          o_entry_cmt_id[e] = i_disp_cmt_id[s];
          o_entry_vaddr[e]  = i_disp_vaddr[s];
        end
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_reset_n) begin
      r_in_ptr_oh <= LDQ_SIZE'(1);
    end else if (w_flush) begin
      r_in_ptr_oh <= LDQ_SIZE'(1);  // queue empties on flush
    end else begin
      r_in_ptr_oh <= rotl(r_in_ptr_oh, int'(w_disp_cnt));
    end
  end

  assign o_ignored_num = w_flush ? w_disp_cnt : '0;

endmodule

// ==== verilog/ldq_entry.sv ====
`timescale 1ns/10ps

module ldq_entry (
  input  logic                          i_clk,
  input  logic                          i_reset_n,

  input  logic                          i_load,
  input  logic [ldq_pkg::CMT_ID_W-1:0]  i_load_cmt_id,
  input  logic [ldq_pkg::VADDR_W-1:0]   i_load_vaddr,

  input  logic                          i_picked,

  input  logic                          i_ex2_valid,
  input  logic                          i_ex2_hit_match,
  input  logic                          i_ex2_miss_match,

  input  logic                          i_reported,

  input  logic                          i_commit_valid,
  input  logic                          i_commit_flush,
  input  logic [ldq_pkg::CMT_ID_W-1:0]  i_commit_cmt_id,

  output ldq_pkg::ldq_state_t           o_state,
  output logic [ldq_pkg::CMT_ID_W-1:0]  o_cmt_id,
  output logic [ldq_pkg::VADDR_W-1:0]   o_vaddr,
  output logic                          o_finish
);

  import ldq_pkg::*;

  ldq_state_t          r_state;
  ldq_state_t          w_state_next;
  logic [CMT_ID_W-1:0] r_cmt_id;
  logic [VADDR_W-1:0]  r_vaddr;
  logic                w_commit_hit;
  logic                w_flush_hit;

  // ----------------------------------------
  // freeing condition
  // ----------------------------------------
  assign w_commit_hit = i_commit_valid & !i_commit_flush &
                        (r_state == LDQ_WAIT_COMPLETE) & (r_cmt_id == i_commit_cmt_id);
  assign w_flush_hit  = i_commit_valid & i_commit_flush & (r_state != LDQ_INIT);
  assign o_finish     = w_commit_hit | w_flush_hit;

  // ----------------------------------------
  // state machine
  // ----------------------------------------
  always_comb begin
    w_state_next = r_state;
    if (o_finish) begin
      w_state_next = LDQ_INIT;
    end else begin
      case (r_state)
        LDQ_INIT: begin
          if (i_load) w_state_next = LDQ_ISSUE_WAIT;
        end
        LDQ_ISSUE_WAIT: begin
          if (i_picked) w_state_next = LDQ_ISSUED;
        end
        LDQ_ISSUED: begin
          if (i_ex2_valid & i_ex2_hit_match) begin
            w_state_next = LDQ_EX3_DONE;
          end else if (i_ex2_valid & i_ex2_miss_match) begin
            w_state_next = LDQ_ISSUE_WAIT;  // replay
          end
        end
        LDQ_EX3_DONE: begin
          if (i_reported) w_state_next = LDQ_WAIT_COMPLETE;
        end
        LDQ_WAIT_COMPLETE: begin
          w_state_next = LDQ_WAIT_COMPLETE;  // left only by commit or flush
        end
        default: begin
          w_state_next = LDQ_INIT;
        end
      endcase
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_reset_n) begin
      r_state <= LDQ_INIT;
    end else begin
      r_state <= w_state_next;
    end
  end

  // payload
  always_ff @(posedge i_clk) begin
    if (i_load) begin
      r_cmt_id <= i_load_cmt_id;
      r_vaddr  <= i_load_vaddr;
    end
  end

  assign o_state  = r_state;
  assign o_cmt_id = r_cmt_id;
  assign o_vaddr  = r_vaddr;

endmodule

// ==== verilog/ldq_issue_select.sv ====
`timescale 1ns/10ps

module ldq_issue_select #(
  parameter int LDQ_SIZE = 8
) (
  input  ldq_pkg::ldq_state_t           i_state  [LDQ_SIZE],
  input  logic [ldq_pkg::CMT_ID_W-1:0]  i_cmt_id [LDQ_SIZE],
  input  logic [ldq_pkg::VADDR_W-1:0]   i_vaddr  [LDQ_SIZE],

  input  logic [LDQ_SIZE-1:0]           i_out_ptr_oh,
  input  logic                          i_issue_conflict,

  output logic                          o_issue_valid,
  output logic [$clog2(LDQ_SIZE)-1:0]   o_issue_index,
  output logic [ldq_pkg::VADDR_W-1:0]   o_issue_vaddr,
  output logic [ldq_pkg::CMT_ID_W-1:0]  o_issue_cmt_id,

  output logic [LDQ_SIZE-1:0]           o_picked
);

  import ldq_pkg::*;

  localparam int IDX_W = $clog2(LDQ_SIZE);

  logic [LDQ_SIZE-1:0] w_req;
  logic [LDQ_SIZE-1:0] w_upper;
  logic [LDQ_SIZE-1:0] w_cand;
  logic [LDQ_SIZE-1:0] w_pick_oh;

  always_comb begin
    for (int e = 0; e < LDQ_SIZE; e++) begin
      w_req[e] = (i_state[e] == LDQ_ISSUE_WAIT);
    end
  end

  // oldest first: entries at or above the out-pointer, then wrap
  assign w_upper   = w_req & ~(i_out_ptr_oh - LDQ_SIZE'(1));
  assign w_cand    = (|w_upper) ? w_upper : w_req;
  assign w_pick_oh = w_cand & (~w_cand + LDQ_SIZE'(1));  // lowest set bit

  always_comb begin
    o_issue_index  = '0;
    o_issue_vaddr  = '0;
    o_issue_cmt_id = '0;
    for (int e = 0; e < LDQ_SIZE; e++) begin
      if (w_pick_oh[e]) begin
        o_issue_index  = IDX_W'(e);
        o_issue_vaddr  = i_vaddr[e];
        o_issue_cmt_id = i_cmt_id[e];
      end
    end
  end

  assign o_issue_valid = |w_req;
  assign o_picked      = i_issue_conflict ? '0 : w_pick_oh;  // refused pick stays waiting

endmodule

// ==== verilog/ldq_done_report.sv ====
`timescale 1ns/10ps

module ldq_done_report #(
  parameter int LDQ_SIZE = 8
) (
  input  ldq_pkg::ldq_state_t           i_state  [LDQ_SIZE],
  input  logic [ldq_pkg::CMT_ID_W-1:0]  i_cmt_id [LDQ_SIZE],
  input  logic [LDQ_SIZE-1:0]           i_out_ptr_oh,

  output logic                          o_done_valid,
  output logic [ldq_pkg::CMT_ID_W-1:0]  o_done_cmt_id,
  output logic [LDQ_SIZE-1:0]           o_reported
);

  import ldq_pkg::*;

  logic [LDQ_SIZE-1:0] w_done;
  logic [LDQ_SIZE-1:0] w_upper;
  logic [LDQ_SIZE-1:0] w_cand;
  logic [LDQ_SIZE-1:0] w_pick_oh;

  always_comb begin
    for (int e = 0; e < LDQ_SIZE; e++) begin
      w_done[e] = (i_state[e] == LDQ_EX3_DONE);
    end
  end

  // same oldest-first search as issue
  assign w_upper   = w_done & ~(i_out_ptr_oh - LDQ_SIZE'(1));
  assign w_cand    = (|w_upper) ? w_upper : w_done;
  assign w_pick_oh = w_cand & (~w_cand + LDQ_SIZE'(1));

  always_comb begin
    o_done_cmt_id = '0;
    for (int e = 0; e < LDQ_SIZE; e++) begin
      if (w_pick_oh[e]) o_done_cmt_id = i_cmt_id[e];
    end
  end

  assign o_done_valid = |w_done;
  assign o_reported   = w_pick_oh;  // one report per load

endmodule

// ==== verilog/ldq_credit_return.sv ====
`timescale 1ns/10ps

module ldq_credit_return #(
  parameter int LDQ_SIZE = 8
) (
  input  logic                                                i_clk,
  input  logic                                                i_reset_n,

  input  logic [LDQ_SIZE-1:0]                                 i_finish,
  input  logic [$clog2(ldq_pkg::DISP_SIZE+1)-1:0]             i_ignored_num,
  input  logic                                                i_commit_valid,
  input  logic                                                i_commit_flush,

  output logic [LDQ_SIZE-1:0]                                 o_out_ptr_oh,
  output logic                                                o_credit_return_valid,
  output logic [$clog2(LDQ_SIZE+ldq_pkg::DISP_SIZE+1)-1:0]    o_credit_return_val
);

  import ldq_pkg::*;

  localparam int CNT_W = $clog2(LDQ_SIZE + 1);
  localparam int CRD_W = $clog2(LDQ_SIZE + DISP_SIZE + 1);

  logic [LDQ_SIZE-1:0] r_out_ptr_oh;
  logic [CNT_W-1:0]    w_finish_cnt;
  logic [CRD_W-1:0]    w_credit_val;
  logic                w_flush;

  function automatic logic [LDQ_SIZE-1:0] rotl(input logic [LDQ_SIZE-1:0] oh, input int amt);
    logic [2*LDQ_SIZE-1:0] dbl;
    dbl = {oh, oh} << amt;
    return dbl[2*LDQ_SIZE-1:LDQ_SIZE];
  endfunction

  assign w_flush = i_commit_valid & i_commit_flush;

  always_comb begin
    w_finish_cnt = '0;
    for (int e = 0; e < LDQ_SIZE; e++) begin
      w_finish_cnt = w_finish_cnt + CNT_W'(i_finish[e]);
    end
  end

  assign w_credit_val = CRD_W'(w_finish_cnt) + CRD_W'(i_ignored_num);

  // ----------------------------------------
  // out-pointer, oldest valid entry
  // ----------------------------------------
  always_ff @(posedge i_clk) begin
    if (i_reset_n) begin
      r_out_ptr_oh <= LDQ_SIZE'(1);
    end else if (w_flush) begin
      r_out_ptr_oh <= LDQ_SIZE'(1);  // matches in-pointer after flush
    end else begin
      r_out_ptr_oh <= rotl(r_out_ptr_oh, int'(w_finish_cnt));
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_reset_n) begin
      o_credit_return_valid <= 1'b0;
    end else begin
      o_credit_return_valid <= (w_credit_val != '0);
    end
  end

  always_ff @(posedge i_clk) begin
    o_credit_return_val <= w_credit_val;
  end

  assign o_out_ptr_oh = r_out_ptr_oh;

endmodule

// ==== verilog/ldq_top.sv ====
`timescale 1ns/10ps

module ldq_top #(
  parameter int LDQ_SIZE = ldq_pkg::LDQ_SIZE
) (
  input  logic                                              i_clk,
  input  logic                                              i_reset_n,

  input  logic [ldq_pkg::DISP_SIZE-1:0]                     i_disp_valid,
  input  logic [ldq_pkg::CMT_ID_W-1:0]                      i_disp_cmt_id [ldq_pkg::DISP_SIZE],
  input  logic [ldq_pkg::VADDR_W-1:0]                       i_disp_vaddr  [ldq_pkg::DISP_SIZE],

  input  logic                                              i_issue_conflict,

  input  logic                                              i_ex2_valid,
  input  logic [$clog2(LDQ_SIZE)-1:0]                       i_ex2_index,
  input  ldq_pkg::ex2_result_t                              i_ex2_result,

  input  logic                                              i_commit_valid,
  input  logic [ldq_pkg::CMT_ID_W-1:0]                      i_commit_cmt_id,
  input  logic                                              i_commit_flush,

  output logic                                              o_issue_valid,
  output logic [$clog2(LDQ_SIZE)-1:0]                       o_issue_index,
  output logic [ldq_pkg::VADDR_W-1:0]                       o_issue_vaddr,
  output logic [ldq_pkg::CMT_ID_W-1:0]                      o_issue_cmt_id,

  output logic                                              o_done_valid,
  output logic [ldq_pkg::CMT_ID_W-1:0]                      o_done_cmt_id,

  output logic                                              o_credit_return_valid,
  output logic [$clog2(LDQ_SIZE+ldq_pkg::DISP_SIZE+1)-1:0]  o_credit_return_val
);

  import ldq_pkg::*;

  localparam int IDX_W = $clog2(LDQ_SIZE);
  localparam int IGN_W = $clog2(DISP_SIZE + 1);

  logic [LDQ_SIZE-1:0] w_entry_load;
  logic [CMT_ID_W-1:0] w_load_cmt_id [LDQ_SIZE];
  logic [VADDR_W-1:0]  w_load_vaddr  [LDQ_SIZE];

  ldq_state_t          w_entry_state  [LDQ_SIZE];
  logic [CMT_ID_W-1:0] w_entry_cmt_id [LDQ_SIZE];
  logic [VADDR_W-1:0]  w_entry_vaddr  [LDQ_SIZE];

  logic [LDQ_SIZE-1:0] w_entry_picked;
  logic [LDQ_SIZE-1:0] w_entry_reported;
  logic [LDQ_SIZE-1:0] w_entry_finish;
  logic [LDQ_SIZE-1:0] w_out_ptr_oh;
  logic [IGN_W-1:0]    w_ignored_num;

  // ----------------------------------------
  // dispatch side
  // ----------------------------------------
  ldq_disp_alloc #(
    .LDQ_SIZE (LDQ_SIZE)
  ) u_disp_alloc (
    .i_clk          (i_clk),
    .i_reset_n      (i_reset_n),
    .i_disp_valid   (i_disp_valid),
    .i_disp_cmt_id  (i_disp_cmt_id),
    .i_disp_vaddr   (i_disp_vaddr),
    .i_commit_valid (i_commit_valid),
    .i_commit_flush (i_commit_flush),
    .o_entry_load   (w_entry_load),
    .o_entry_cmt_id (w_load_cmt_id),
    .o_entry_vaddr  (w_load_vaddr),
    .o_ignored_num  (w_ignored_num)
  );

  // ----------------------------------------
  // entries
  // ----------------------------------------
  for (genvar l_idx = 0; l_idx < LDQ_SIZE; l_idx++) begin : g_entry
    logic w_ex2_idx_match;

    assign w_ex2_idx_match = (i_ex2_index == IDX_W'(l_idx));  // EX2 names entry by index

    ldq_entry u_entry (
      .i_clk            (i_clk),
      .i_reset_n        (i_reset_n),
      .i_load           (w_entry_load[l_idx]),
      .i_load_cmt_id    (w_load_cmt_id[l_idx]),
      .i_load_vaddr     (w_load_vaddr[l_idx]),
      .i_picked         (w_entry_picked[l_idx]),
      .i_ex2_valid      (i_ex2_valid),
      .i_ex2_hit_match  (w_ex2_idx_match & (i_ex2_result == EX2_HIT)),
      .i_ex2_miss_match (w_ex2_idx_match & (i_ex2_result == EX2_MISS)),
      .i_reported       (w_entry_reported[l_idx]),
      .i_commit_valid   (i_commit_valid),
      .i_commit_flush   (i_commit_flush),
      .i_commit_cmt_id  (i_commit_cmt_id),
      .o_state          (w_entry_state[l_idx]),
      .o_cmt_id         (w_entry_cmt_id[l_idx]),
      .o_vaddr          (w_entry_vaddr[l_idx]),
      .o_finish         (w_entry_finish[l_idx])
    );
  end

  // replay pick into the LSU pipe
  ldq_issue_select #(
    .LDQ_SIZE (LDQ_SIZE)
  ) u_issue_select (
    .i_state          (w_entry_state),
    .i_cmt_id         (w_entry_cmt_id),
    .i_vaddr          (w_entry_vaddr),
    .i_out_ptr_oh     (w_out_ptr_oh),
    .i_issue_conflict (i_issue_conflict),
    .o_issue_valid    (o_issue_valid),
    .o_issue_index    (o_issue_index),
    .o_issue_vaddr    (o_issue_vaddr),
    .o_issue_cmt_id   (o_issue_cmt_id),
    .o_picked         (w_entry_picked)
  );

  ldq_done_report #(
    .LDQ_SIZE (LDQ_SIZE)
  ) u_done_report (
    .i_state       (w_entry_state),
    .i_cmt_id      (w_entry_cmt_id),
    .i_out_ptr_oh  (w_out_ptr_oh),
    .o_done_valid  (o_done_valid),
    .o_done_cmt_id (o_done_cmt_id),
    .o_reported    (w_entry_reported)
  );

  ldq_credit_return #(
    .LDQ_SIZE (LDQ_SIZE)
  ) u_credit_return (
    .i_clk                 (i_clk),
    .i_reset_n             (i_reset_n),
    .i_finish              (w_entry_finish),
    .i_ignored_num         (w_ignored_num),
    .i_commit_valid        (i_commit_valid),
    .i_commit_flush        (i_commit_flush),
    .o_out_ptr_oh          (w_out_ptr_oh),
    .o_credit_return_valid (o_credit_return_valid),
    .o_credit_return_val   (o_credit_return_val)
  );

endmodule

// ==== sim/tb_ldq.sv ====
`timescale 1ns/10ps

module tb_ldq;

  import ldq_pkg::*;

  localparam int SIZE      = 8;
  localparam int IDX_W     = $clog2(SIZE);
  localparam int CRD_W     = $clog2(SIZE + DISP_SIZE + 1);
  localparam int NUM_LOADS = 28;  // 2 + 16 + 6 + 2 + 2 over all phases

  logic                 clk = 1'b0;
  logic                 reset_n;
  logic [DISP_SIZE-1:0] disp_valid;
  logic [CMT_ID_W-1:0]  disp_cmt_id [DISP_SIZE];
  logic [VADDR_W-1:0]   disp_vaddr  [DISP_SIZE];
  logic                 issue_conflict;
  logic                 ex2_valid;
  logic [IDX_W-1:0]     ex2_index;
  ex2_result_t          ex2_result;
  logic                 commit_valid;
  logic [CMT_ID_W-1:0]  commit_cmt_id;
  logic                 commit_flush;
  logic                 issue_valid;
  logic [IDX_W-1:0]     issue_index;
  logic [VADDR_W-1:0]   issue_vaddr;
  logic [CMT_ID_W-1:0]  issue_cmt_id;
  logic                 done_valid;
  logic [CMT_ID_W-1:0]  done_cmt_id;
  logic                 credit_valid;
  logic [CRD_W-1:0]     credit_val;

  // reference queue
  ldq_state_t           m_state [SIZE];
  logic [CMT_ID_W-1:0]  m_cmt   [SIZE];
  logic [VADDR_W-1:0]   m_vaddr [SIZE];
  int                   m_in;
  int                   m_out;
  int                   m_pending;
  int                   disp_total;  // loads dispatched, written or ignored
  int                   credit_total;

  int                   seed;
  int                   next_id;
  bit                   pend_valid;
  logic [IDX_W-1:0]     pend_index;
  bit                   miss_seen;
  string                test_name;

  always #50 clk = ~clk;

  ldq_top #(
    .LDQ_SIZE (SIZE)
  ) dut0 (
    .i_clk                 (clk),
    .i_reset_n             (reset_n),
    .i_disp_valid          (disp_valid),
    .i_disp_cmt_id         (disp_cmt_id),
    .i_disp_vaddr          (disp_vaddr),
    .i_issue_conflict      (issue_conflict),
    .i_ex2_valid           (ex2_valid),
    .i_ex2_index           (ex2_index),
    .i_ex2_result          (ex2_result),
    .i_commit_valid        (commit_valid),
    .i_commit_cmt_id       (commit_cmt_id),
    .i_commit_flush        (commit_flush),
    .o_issue_valid         (issue_valid),
    .o_issue_index         (issue_index),
    .o_issue_vaddr         (issue_vaddr),
    .o_issue_cmt_id        (issue_cmt_id),
    .o_done_valid          (done_valid),
    .o_done_cmt_id         (done_cmt_id),
    .o_credit_return_valid (credit_valid),
    .o_credit_return_val   (credit_val)
  );

  task automatic report_mismatch(input string what, input logic [63:0] exp,
                                 input logic [63:0] act);
    $display("FAIL %s: %s expected %0h actual %0h", test_name, what, exp, act);
    $display("Regression failed");
    $fatal(1, "stopped at first mismatch");
  endtask

  // oldest entry in a state, searched from the out-pointer
  function automatic int oldest_in_state(input ldq_state_t want);
    int idx;
    for (int k = 0; k < SIZE; k++) begin
      idx = (m_out + k) % SIZE;
      if (m_state[idx] == want) return idx;
    end
    return -1;
  endfunction

  function automatic int count_free();
    int n;
    n = 0;
    for (int e = 0; e < SIZE; e++) begin
      if (m_state[e] == LDQ_INIT) n++;
    end
    return n;
  endfunction

  // ----------------------------------------
  // checks and model update
  // ----------------------------------------
  always @(posedge clk) begin : model_check
    int iss;
    int dn;
    int fin;
    int cnt;
    int e;
    int held;
    bit flush;
    bit freeing [SIZE];
    if (reset_n) begin
      for (e = 0; e < SIZE; e++) m_state[e] = LDQ_INIT;
      m_in      = 0;
      m_out     = 0;
      m_pending = 0;
    end else begin
      iss = oldest_in_state(LDQ_ISSUE_WAIT);
      dn  = oldest_in_state(LDQ_EX3_DONE);
      assert (issue_valid == (iss >= 0))
        else report_mismatch("issue_valid", 64'(iss >= 0), 64'(issue_valid));
      if (iss >= 0) begin
        assert (issue_index == IDX_W'(iss))
          else report_mismatch("issue_index", 64'(iss), 64'(issue_index));
        assert (issue_vaddr == m_vaddr[iss])
          else report_mismatch("issue_vaddr", 64'(m_vaddr[iss]), 64'(issue_vaddr));
        assert (issue_cmt_id == m_cmt[iss])
          else report_mismatch("issue_cmt_id", 64'(m_cmt[iss]), 64'(issue_cmt_id));
      end
      assert (done_valid == (dn >= 0))
        else report_mismatch("done_valid", 64'(dn >= 0), 64'(done_valid));
      if (dn >= 0) begin
        assert (done_cmt_id == m_cmt[dn])
          else report_mismatch("done_cmt_id", 64'(m_cmt[dn]), 64'(done_cmt_id));
      end
      assert (credit_valid == (m_pending != 0))
        else report_mismatch("credit_valid", 64'(m_pending != 0), 64'(credit_valid));
      if (m_pending != 0) begin
        assert (credit_val == CRD_W'(m_pending))
          else report_mismatch("credit_val", 64'(m_pending), 64'(credit_val));
      end

      // every dispatched load is either still held or has returned its credit
      held = SIZE - count_free();
      if (credit_valid) credit_total += int'(credit_val);
      assert (credit_total == disp_total - held)
        else report_mismatch("credit total", 64'(disp_total - held), 64'(credit_total));

      flush = commit_valid && commit_flush;
      fin   = 0;
      for (e = 0; e < SIZE; e++) begin
        freeing[e] = (flush && m_state[e] != LDQ_INIT) ||
                     (commit_valid && !commit_flush && m_state[e] == LDQ_WAIT_COMPLETE &&
                      m_cmt[e] == commit_cmt_id);
        if (freeing[e]) fin++;
      end
      for (e = 0; e < SIZE; e++) begin
        if (freeing[e]) begin
          m_state[e] = LDQ_INIT;
        end else begin
          case (m_state[e])
            LDQ_ISSUE_WAIT: if (e == iss && !issue_conflict) m_state[e] = LDQ_ISSUED;
            LDQ_ISSUED: begin
              if (ex2_valid && ex2_index == IDX_W'(e)) begin
                if (ex2_result == EX2_HIT) m_state[e] = LDQ_EX3_DONE;
                else m_state[e] = LDQ_ISSUE_WAIT;  // miss goes back to waiting
              end
            end
            LDQ_EX3_DONE: if (e == dn) m_state[e] = LDQ_WAIT_COMPLETE;
            default: ;
          endcase
        end
      end
      cnt = 0;
      for (int s = 0; s < DISP_SIZE; s++) begin
        if (disp_valid[s]) begin
          if (!flush) begin
            e          = (m_in + cnt) % SIZE;
            m_state[e] = LDQ_ISSUE_WAIT;
            m_cmt[e]   = disp_cmt_id[s];
            m_vaddr[e] = disp_vaddr[s];
          end
          cnt++;
        end
      end
      m_pending   = flush ? fin + cnt : fin;  // ignored loads return credits too
      disp_total += cnt;
      m_in        = flush ? 0 : (m_in + cnt) % SIZE;
      m_out       = flush ? 0 : (m_out + fin) % SIZE;
    end
  end

  // ----------------------------------------
  // stimulus
  // ----------------------------------------
  task automatic drive_idle();
    disp_valid     = '0;
    issue_conflict = 1'b0;
    ex2_valid      = 1'b0;
    ex2_index      = '0;
    ex2_result     = EX2_HIT;
    commit_valid   = 1'b0;
    commit_cmt_id  = '0;
    commit_flush   = 1'b0;
    for (int s = 0; s < DISP_SIZE; s++) begin
      disp_cmt_id[s] = '0;
      disp_vaddr[s]  = '0;
    end
  endtask

  task automatic drive_cycle(input bit disp_two, input bit flush);
    drive_idle();
    if (pend_valid) begin  // EX2 result for last cycle's pick
      ex2_valid = 1'b1;
      ex2_index = pend_index;
      if (!miss_seen || ($random(seed) & 3) == 0) begin
        ex2_result = EX2_MISS;
        miss_seen  = 1'b1;
      end
    end
    pend_valid = 1'b0;
    if (issue_valid) begin
      issue_conflict = (($random(seed) & 3) == 0);
      pend_valid     = !issue_conflict && !flush;
      pend_index     = issue_index;
    end
    if (flush) begin
      commit_valid = 1'b1;
      commit_flush = 1'b1;
    end else if (m_state[m_out] == LDQ_WAIT_COMPLETE) begin
      commit_valid  = 1'b1;  // commits in program order
      commit_cmt_id = m_cmt[m_out];
    end
    if (disp_two) begin
      for (int s = 0; s < DISP_SIZE; s++) begin
        disp_valid[s]  = 1'b1;
        disp_cmt_id[s] = CMT_ID_W'(next_id);
        disp_vaddr[s]  = $random(seed);
        next_id        = (next_id + 1) % 64;
      end
    end
  endtask

  task automatic run_until_empty(input int pairs);
    while (pairs > 0 || count_free() != SIZE) begin
      @(negedge clk);
      if (pairs > 0 && count_free() >= DISP_SIZE) begin
        drive_cycle(1'b1, 1'b0);
        pairs--;
      end else begin
        drive_cycle(1'b0, 1'b0);
      end
    end
  endtask

  initial begin : stimulus
    seed       = 32'h6f7b;
    next_id    = 1;
    pend_valid = 1'b0;
    pend_index = '0;
    miss_seen  = 1'b0;
    test_name  = "reset";
    reset_n    = 1'b1;
    drive_idle();
    repeat (10) @(posedge clk);
    @(negedge clk);
    reset_n = 1'b0;

    @(negedge clk);
    test_name = "dispatch_issue_order";
    drive_cycle(1'b1, 1'b0);
    run_until_empty(0);

    test_name = "replay_done_commit";
    run_until_empty(8);

    test_name = "flush";
    for (int p = 0; p < 3; p++) begin
      @(negedge clk);
      drive_cycle(1'b1, 1'b0);
    end
    repeat (3) begin
      @(negedge clk);
      drive_cycle(1'b0, 1'b0);
    end
    @(negedge clk);
    drive_cycle(1'b1, 1'b1);
    repeat (5) begin  // nothing may issue here
      @(negedge clk);
      drive_cycle(1'b0, 1'b0);
    end

    test_name = "after_flush";
    run_until_empty(1);
    repeat (3) begin
      @(negedge clk);
      drive_cycle(1'b0, 1'b0);
    end
    @(negedge clk);

    $display("Regression passed");
    $finish;
  end

  initial begin : watchdog
    repeat (NUM_LOADS * 40 + 200) @(posedge clk);
    $display("ERROR: watchdog expired before the test sequence finished");
    $display("Regression failed");
    $fatal(1, "timeout");
  end

endmodule

// ==== list.f ====
verilog/ldq_pkg.sv
verilog/ldq_disp_alloc.sv
verilog/ldq_entry.sv
verilog/ldq_issue_select.sv
verilog/ldq_done_report.sv
verilog/ldq_credit_return.sv
verilog/ldq_top.sv
sim/tb_ldq.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the LDQ testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -j 0 \
  --top-module tb_ldq \
  -f list.f \
  -o tb_ldq_sim

# the exit status of tee is kept, the log decides the result
./obj_dir/tb_ldq_sim 2>&1 | tee sim.log

if grep -q "Regression failed" sim.log; then
  echo "run_sim: simulation reported a failure"
  exit 1
fi

echo "run_sim: no failure found in sim.log"
exit 0
